// File: irq_ctrl_pkg.sv
/* Interrupt map, widths and types shared by the interrupt and sleep controller.
   Imported by every RTL block and by the assertion module. */
package irq_ctrl_pkg;

  // ----------------------------------------
  // Interrupt map
  // ----------------------------------------

  // One line per machine interrupt number
  localparam int unsigned NUM_IRQ = 32;

  // Lines that exist: 31..16, 11, 7 and 3
  localparam logic [NUM_IRQ-1:0] VALID_IRQ_MASK = 32'hffff_0888;

  localparam int unsigned IRQ_ID_W = $clog2(NUM_IRQ);

  typedef logic [NUM_IRQ-1:0]  irq_vec_t;
  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  // mtvec.MODE encoding
  typedef enum logic [1:0] {
    DIRECT   = 2'b00,
    VECTORED = 2'b01
  } mtvec_mode_e;

  // Default handler address width
  localparam int unsigned ADDR_W = 32;

  // ----------------------------------------
  // Sleep timing
  // ----------------------------------------

  // Cycles from a retiring WFI to sleep with a quiet pipeline
  localparam int unsigned WFI_SLEEP_DELAY = 2;

  localparam int unsigned WFI_CNT_W = $clog2(WFI_SLEEP_DELAY + 1);

  typedef logic [WFI_CNT_W-1:0] wfi_cnt_t;

endpackage

// File: irq_pend_if.sv
/* Registered interrupt state passed from the input side to the arbiter
   and to the WFI sleep controller. */
interface irq_pend_if
  import irq_ctrl_pkg::*;
();

  // Pending lines already masked by mie
  irq_vec_t pend_en;
  // mstatus.MIE
  logic     global_en;
  logic     dbg_req;
  logic     nmi_req;

  modport source (
    output pend_en,
    output global_en,
    output dbg_req,
    output nmi_req
  );

  modport arb (
    input pend_en,
    input global_en
  );

  modport sleep (
    input pend_en,
    input dbg_req,
    input nmi_req
  );

endinterface

// File: irq_pending_regs.sv
/* Input side of the controller. Registers the asynchronous interrupt,
   debug and NMI requests and forms the enabled pending set. */
module irq_pending_regs
  import irq_ctrl_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  irq_vec_t          irq_i,
  input  irq_vec_t          mie_i,
  input  logic              mstatus_mie_i,
  input  logic              debug_req_i,
  input  logic              nmi_i,
  output irq_vec_t          mip_o,
  irq_pend_if.source        pend
);

  irq_vec_t mip_q;
  logic     dbg_q;
  logic     nmi_q;

  // Reserved lines never reach mip
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
      dbg_q <= 1'b0;
      nmi_q <= 1'b0;
    end else begin
      mip_q <= irq_i & VALID_IRQ_MASK;
      dbg_q <= debug_req_i;
      nmi_q <= nmi_i;
    end
  end

  assign mip_o = mip_q;

  // Enabled pending set seen by the arbiter and the sleep logic
  assign pend.pend_en   = mip_q & mie_i;
  assign pend.global_en = mstatus_mie_i;
  assign pend.dbg_req   = dbg_q;
  assign pend.nmi_req   = nmi_q;

endmodule

// File: irq_arbiter.sv
/* Fixed-priority interrupt arbiter with a one-entry output slot.
   The slot holds its choice until taken, then stays idle for a cycle. */
module irq_arbiter
  import irq_ctrl_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  irq_pend_if.arb  pend,
  output logic     arb_valid_o,
  input  logic     arb_ready_i,
  output irq_id_t  arb_id_o
);

  irq_id_t win_id;
  logic    win_found;
  logic    load;
  logic    xfer;
  logic    valid_q;
  irq_id_t id_q;

  // ----------------------------------------
  // Priority encoder
  // ----------------------------------------

  // Lowest priority first so that later hits override
  always_comb begin
    win_id = '0;
    if (pend.pend_en[7]) begin
      win_id = irq_id_t'(7);
    end
    if (pend.pend_en[3]) begin
      win_id = irq_id_t'(3);
    end
    if (pend.pend_en[11]) begin
      win_id = irq_id_t'(11);
    end
    // Platform lines, 31 wins
    for (int i = 16; i < NUM_IRQ; i++) begin
      if (pend.pend_en[i]) begin
        win_id = irq_id_t'(i);
      end
    end
  end

  assign win_found = |pend.pend_en;

  // ----------------------------------------
  // Output slot
  // ----------------------------------------

  assign xfer = valid_q && arb_ready_i;
  // A slot freed by a transfer reads empty only on the next edge
  assign load = !valid_q && pend.global_en && win_found;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (xfer) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      id_q <= win_id;
    end
  end

  assign arb_valid_o = valid_q;
  assign arb_id_o    = id_q;

endmodule

// File: wfi_sleep_ctrl.sv
/* WFI wait and sleep FSM. Raises core_sleep_o after the fixed delay with a
   quiet pipeline and pulses wfi_done_o when a wake source ends the WFI. */
module wfi_sleep_ctrl
  import irq_ctrl_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  irq_pend_if.sleep  pend,
  input  logic       wfi_i,
  input  logic       instr_outstanding_i,
  input  logic       lsu_busy_i,
  output logic       core_sleep_o,
  output logic       wfi_done_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT,
    S_SLEEP
  } sleep_state_e;

  sleep_state_e state_q;
  sleep_state_e state_d;
  wfi_cnt_t     cnt_q;
  wfi_cnt_t     cnt_d;
  logic         done_q;
  logic         done_d;
  logic         wake;
  logic         quiet;

  // Wake on any enabled pending line, regardless of mstatus.MIE
  assign wake  = (|pend.pend_en) || pend.dbg_req || pend.nmi_req;
  assign quiet = !instr_outstanding_i && !lsu_busy_i;

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    done_d  = 1'b0;
    unique case (state_q)
      S_IDLE: begin
        if (wfi_i) begin
          state_d = S_WAIT;
          cnt_d   = wfi_cnt_t'(WFI_SLEEP_DELAY - 1);
        end
      end
      S_WAIT: begin
        if (wake) begin
          state_d = S_IDLE;
          done_d  = 1'b1;
        end else if (cnt_q != '0) begin
          cnt_d = cnt_q - 1'b1;
        end else if (quiet) begin
          state_d = S_SLEEP;
        end
      end
      S_SLEEP: begin
        if (wake) begin
          state_d = S_IDLE;
          done_d  = 1'b1;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      done_q  <= done_d;
    end
  end

  assign core_sleep_o = (state_q == S_SLEEP);
  assign wfi_done_o   = done_q;

endmodule

// File: irq_out_stage.sv
/* Request register towards the core. Computes the handler address from
   mtvec on load and holds the request under back-pressure. */
module irq_out_stage
  import irq_ctrl_pkg::*;
#(
  parameter int unsigned ADDR_W = irq_ctrl_pkg::ADDR_W
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              arb_valid_i,
  output logic              arb_ready_o,
  input  irq_id_t           arb_id_i,
  input  logic [ADDR_W-1:0] mtvec_base_i,
  input  mtvec_mode_e       mtvec_mode_i,
  output logic              irq_valid_o,
  input  logic              irq_ready_i,
  output irq_id_t           irq_id_o,
  output logic [ADDR_W-1:0] irq_addr_o
);

  logic              full_q;
  logic              load;
  irq_id_t           id_q;
  logic [ADDR_W-1:0] addr_d;
  logic [ADDR_W-1:0] addr_q;

  // Ready when empty or when the core drains the stage this cycle
  assign arb_ready_o = !full_q || irq_ready_i;
  assign load        = arb_valid_i && arb_ready_o;

  // Vectored mode jumps to base + 4 * cause
  always_comb begin
    if (mtvec_mode_i == VECTORED) begin
      addr_d = mtvec_base_i + (ADDR_W'(arb_id_i) << 2);
    end else begin
      addr_d = mtvec_base_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (irq_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      id_q   <= arb_id_i;
      addr_q <= addr_d;
    end
  end

  assign irq_valid_o = full_q;
  assign irq_id_o    = id_q;
  assign irq_addr_o  = addr_q;

endmodule

// File: irq_ctrl_top.sv
/* Top level of the interrupt and sleep controller.
   Wires the input registers, arbiter, sleep FSM and output stage. */
module irq_ctrl_top
  import irq_ctrl_pkg::*;
#(
  parameter int unsigned ADDR_W = irq_ctrl_pkg::ADDR_W
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Interrupt sources and CSR state
  input  irq_vec_t          irq_i,
  input  irq_vec_t          mie_i,
  input  logic              mstatus_mie_i,
  input  logic              debug_req_i,
  input  logic              nmi_i,
  input  logic [ADDR_W-1:0] mtvec_base_i,
  input  mtvec_mode_e       mtvec_mode_i,
  output irq_vec_t          mip_o,
  // Request channel to the core
  output logic              irq_valid_o,
  input  logic              irq_ready_i,
  output irq_id_t           irq_id_o,
  output logic [ADDR_W-1:0] irq_addr_o,
  // WFI and sleep
  input  logic              wfi_i,
  input  logic              instr_outstanding_i,
  input  logic              lsu_busy_i,
  output logic              core_sleep_o,
  output logic              wfi_done_o
);

  logic    arb_valid;
  logic    arb_ready;
  irq_id_t arb_id;

  irq_pend_if i_pend ();

  irq_pending_regs i_pending_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .irq_i         (irq_i),
    .mie_i         (mie_i),
    .mstatus_mie_i (mstatus_mie_i),
    .debug_req_i   (debug_req_i),
    .nmi_i         (nmi_i),
    .mip_o         (mip_o),
    .pend          (i_pend.source)
  );

  irq_arbiter i_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .pend        (i_pend.arb),
    .arb_valid_o (arb_valid),
    .arb_ready_i (arb_ready),
    .arb_id_o    (arb_id)
  );

  wfi_sleep_ctrl i_sleep_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .pend                (i_pend.sleep),
    .wfi_i               (wfi_i),
    .instr_outstanding_i (instr_outstanding_i),
    .lsu_busy_i          (lsu_busy_i),
    .core_sleep_o        (core_sleep_o),
    .wfi_done_o          (wfi_done_o)
  );

  irq_out_stage #(
    .ADDR_W (ADDR_W)
  ) i_out_stage (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .arb_valid_i  (arb_valid),
    .arb_ready_o  (arb_ready),
    .arb_id_i     (arb_id),
    .mtvec_base_i (mtvec_base_i),
    .mtvec_mode_i (mtvec_mode_i),
    .irq_valid_o  (irq_valid_o),
    .irq_ready_i  (irq_ready_i),
    .irq_id_o     (irq_id_o),
    .irq_addr_o   (irq_addr_o)
  );

endmodule

// File: irq_ctrl_sva.sv
/* Concurrent checks for the interrupt and sleep controller.
   Bound into irq_ctrl_top; the testbench reads fail_cnt at the end. */
module irq_ctrl_sva
  import irq_ctrl_pkg::*;
#(
  parameter int unsigned ADDR_W = irq_ctrl_pkg::ADDR_W
) (
  input logic              clk_i,
  input logic              rst_ni,
  input irq_vec_t          irq_i,
  input irq_vec_t          mie_i,
  input logic              mstatus_mie_i,
  input logic              debug_req_i,
  input logic              nmi_i,
  input logic [ADDR_W-1:0] mtvec_base_i,
  input mtvec_mode_e       mtvec_mode_i,
  input irq_vec_t          mip_o,
  input logic              irq_valid_o,
  input logic              irq_ready_i,
  input irq_id_t           irq_id_o,
  input logic [ADDR_W-1:0] irq_addr_o,
  input logic              wfi_i,
  input logic              instr_outstanding_i,
  input logic              lsu_busy_i,
  input logic              core_sleep_o,
  input logic              wfi_done_o,
  input logic              arb_valid,
  input logic              arb_ready,
  input irq_id_t           arb_id
);

  int fail_cnt = 0;

  logic quiet;
  logic no_wake;
  logic [ADDR_W-1:0] exp_addr;

  // Priority order: 31 down to 16, then 11, 3, 7
  function automatic irq_id_t top_priority(irq_vec_t v);
    irq_id_t id;
    logic    found;
    id    = '0;
    found = 1'b0;
    for (int i = NUM_IRQ - 1; i >= 16; i--) begin
      if (!found && v[i]) begin
        id    = irq_id_t'(i);
        found = 1'b1;
      end
    end
    if (!found && v[11]) begin
      id    = irq_id_t'(11);
      found = 1'b1;
    end
    if (!found && v[3]) begin
      id    = irq_id_t'(3);
      found = 1'b1;
    end
    if (!found && v[7]) begin
      id = irq_id_t'(7);
    end
    return id;
  endfunction

  assign quiet     = !instr_outstanding_i && !lsu_busy_i;
  assign no_wake   = !(|(mip_o & mie_i)) && !debug_req_i && !nmi_i;
  assign exp_addr  = (mtvec_mode_i == VECTORED) ? mtvec_base_i + {irq_id_o, 2'b00}
                                                : mtvec_base_i;

  // ----------------------------------------
  // Pending register and reset state
  // ----------------------------------------
  a_mip : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) |-> mip_o == ($past(irq_i) & VALID_IRQ_MASK))
    else begin
      fail_cnt++;
      $error("error mip_o %h expected %h", mip_o, $past(irq_i) & VALID_IRQ_MASK);
    end

  a_reset : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$past(rst_ni) |-> !irq_valid_o && !core_sleep_o && !wfi_done_o && mip_o == '0)
    else begin
      fail_cnt++;
      $error("outputs were not cleared by reset");
    end

  // ----------------------------------------
  // Arbitration and delivery
  // ----------------------------------------
  a_latency : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mstatus_mie_i && !irq_valid_o && $rose(|(irq_i & mie_i & VALID_IRQ_MASK))
    |-> ##[1:3] irq_valid_o)
    else begin
      fail_cnt++;
      $error("interrupt request did not reach the core within three cycles");
    end

  a_winner : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(arb_valid) |-> $past(mstatus_mie_i) && arb_id == top_priority($past(mip_o & mie_i)))
    else begin
      fail_cnt++;
      $error("error arb_id %h expected %h", arb_id, top_priority($past(mip_o & mie_i)));
    end

  a_legal_id : assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_valid_o |-> VALID_IRQ_MASK[irq_id_o] && mie_i[irq_id_o])
    else begin
      fail_cnt++;
      $error("error irq_id_o %h is reserved or disabled", irq_id_o);
    end

  a_handoff : assert property (@(posedge clk_i) disable iff (!rst_ni)
    arb_valid && arb_ready |=> irq_valid_o && irq_id_o == $past(arb_id))
    else begin
      fail_cnt++;
      $error("error irq_id_o %h expected %h", irq_id_o, $past(arb_id));
    end

  a_arb_idle : assert property (@(posedge clk_i) disable iff (!rst_ni)
    arb_valid && arb_ready |=> !arb_valid)
    else begin
      fail_cnt++;
      $error("arbiter skipped the idle cycle after a transfer");
    end

  a_arb_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    arb_valid && !arb_ready |=> arb_valid && $stable(arb_id))
    else begin
      fail_cnt++;
      $error("arbiter dropped or changed a request under back-pressure");
    end

  a_out_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_valid_o && !irq_ready_i |=> irq_valid_o && $stable(irq_id_o) && $stable(irq_addr_o))
    else begin
      fail_cnt++;
      $error("core request changed under back-pressure");
    end

  a_addr : assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_valid_o |-> irq_addr_o == exp_addr)
    else begin
      fail_cnt++;
      $error("error irq_addr_o %h expected %h", irq_addr_o, exp_addr);
    end

  // ----------------------------------------
  // WFI sleep
  // ----------------------------------------
  a_sleep_entry : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wfi_i && !core_sleep_o && quiet && no_wake) ##1 (quiet && no_wake)[*2]
    |=> core_sleep_o && $past(!core_sleep_o))
    else begin
      fail_cnt++;
      $error("core_sleep_o did not rise two cycles after the WFI");
    end

  a_busy : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !core_sleep_o && !quiet |=> !core_sleep_o)
    else begin
      fail_cnt++;
      $error("core went to sleep with a busy pipeline");
    end

  a_wake : assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o && ($rose(|(irq_i & mie_i & VALID_IRQ_MASK)) || $rose(debug_req_i) ||
    $rose(nmi_i)) |=> core_sleep_o ##1 (!core_sleep_o && wfi_done_o) ##1 !wfi_done_o)
    else begin
      fail_cnt++;
      $error("wake did not end sleep two cycles later with a done pulse");
    end

  a_done_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wfi_done_o |=> !wfi_done_o)
    else begin
      fail_cnt++;
      $error("wfi_done_o stayed high for more than one cycle");
    end

endmodule

bind irq_ctrl_top irq_ctrl_sva #(.ADDR_W(ADDR_W)) i_sva (.*);

// File: tb_irq_ctrl.sv
/* Testbench for irq_ctrl_top. Drives interrupt, back-pressure and WFI
   traffic; the bound assertions do the checking. */
module tb_irq_ctrl;
  import irq_ctrl_pkg::*;

  logic        clk_i;
  logic        rst_ni;
  irq_vec_t    irq_i;
  irq_vec_t    mie_i;
  logic        mstatus_mie_i;
  logic        debug_req_i;
  logic        nmi_i;
  logic [31:0] mtvec_base_i;
  mtvec_mode_e mtvec_mode_i;
  irq_vec_t    mip_o;
  logic        irq_valid_o;
  logic        irq_ready_i;
  irq_id_t     irq_id_o;
  logic [31:0] irq_addr_o;
  logic        wfi_i;
  logic        instr_outstanding_i;
  logic        lsu_busy_i;
  logic        core_sleep_o;
  logic        wfi_done_o;

  integer      seed;
  logic [31:0] rnd;
  int          timeout_cnt;
  int          total;

  irq_ctrl_top #(.ADDR_W(32)) i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic wait_valid(input int max);
    int i;
    i = 0;
    while (!irq_valid_o && i < max) begin
      @(posedge clk_i);
      i++;
    end
    if (!irq_valid_o) begin
      timeout_cnt++;
      $display("timeout: no interrupt request reached the core");
    end
  endtask

  // Idle means three low cycles of irq_valid_o in a row
  task automatic wait_drained(input int max);
    int i;
    int low;
    i   = 0;
    low = 0;
    while (low < 3 && i < max) begin
      @(posedge clk_i);
      low = irq_valid_o ? 0 : low + 1;
      i++;
    end
    if (low < 3) begin
      timeout_cnt++;
      $display("timeout: interrupt channel did not go idle");
    end
  endtask

  task automatic wait_sleep(input logic level, input int max);
    int i;
    i = 0;
    while (core_sleep_o !== level && i < max) begin
      @(posedge clk_i);
      i++;
    end
    if (core_sleep_o !== level) begin
      timeout_cnt++;
      $display("timeout: core_sleep_o never reached %0b", level);
    end
  endtask

  task automatic deliver(input irq_vec_t pat, input mtvec_mode_e mode, input logic [31:0] base);
    mtvec_mode_i <= mode;
    mtvec_base_i <= base;
    irq_i        <= pat;
    wait_valid(8);
    cycles(4);
    irq_i <= '0;
    wait_drained(50);
  endtask

  task automatic pulse_wfi();
    wfi_i <= 1'b1;
    @(posedge clk_i);
    wfi_i <= 1'b0;
  endtask

  initial begin
    seed                = 32'h0d2e_3389;
    timeout_cnt         = 0;
    rst_ni              = 1'b0;
    irq_i               = '0;
    mie_i               = '0;
    mstatus_mie_i       = 1'b0;
    debug_req_i         = 1'b0;
    nmi_i               = 1'b0;
    mtvec_base_i        = '0;
    mtvec_mode_i        = DIRECT;
    irq_ready_i         = 1'b0;
    wfi_i               = 1'b0;
    instr_outstanding_i = 1'b0;
    lsu_busy_i          = 1'b0;
    cycles(4);
    rst_ni <= 1'b1;
    cycles(2);

    // ----------------------------------------
    // Priority, masking and handler address
    // ----------------------------------------
    mie_i         <= 32'h00ff_0888;
    mstatus_mie_i <= 1'b1;
    irq_ready_i   <= 1'b1;
    cycles(1);
    deliver(32'h0000_0088, DIRECT, 32'h0000_1000);
    deliver(32'h0000_0808, VECTORED, 32'h0000_2000);
    deliver(32'h0001_0800, VECTORED, 32'h0000_3000);
    deliver(32'h8001_0000, DIRECT, 32'h0000_4000);
    for (int k = 0; k < 12; k++) begin
      deliver($random(seed) | 32'h80, (k % 2) ? VECTORED : DIRECT, $random(seed) & 32'hffff_ff00);
    end

    // Random back-pressure from the core
    for (int k = 0; k < 240; k++) begin
      @(posedge clk_i);
      rnd         = $random(seed);
      irq_ready_i <= rnd[0];
      if (k % 30 == 0) begin
        irq_i <= $random(seed) | 32'h8;
      end
    end
    irq_i       <= '0;
    irq_ready_i <= 1'b1;
    wait_drained(50);

    // ----------------------------------------
    // WFI sleep and wake
    // ----------------------------------------
    mstatus_mie_i <= 1'b0;
    cycles(2);
    pulse_wfi();
    wait_sleep(1'b1, 10);
    cycles(3);
    irq_i <= 32'h0001_0000;
    wait_sleep(1'b0, 10);
    cycles(2);
    irq_i <= '0;
    cycles(4);

    lsu_busy_i <= 1'b1;
    pulse_wfi();
    cycles(5);
    lsu_busy_i <= 1'b0;
    wait_sleep(1'b1, 10);
    cycles(2);
    debug_req_i <= 1'b1;
    wait_sleep(1'b0, 10);
    debug_req_i <= 1'b0;
    cycles(4);

    instr_outstanding_i <= 1'b1;
    pulse_wfi();
    cycles(3);
    instr_outstanding_i <= 1'b0;
    wait_sleep(1'b1, 10);
    cycles(2);
    nmi_i <= 1'b1;
    wait_sleep(1'b0, 10);
    nmi_i <= 1'b0;
    cycles(5);

    total = timeout_cnt + i_dut.i_sva.fail_cnt;
    $display("assertion failures %0d, timeouts %0d", i_dut.i_sva.fail_cnt, timeout_cnt);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Run time limit
  initial begin
    repeat (20000) @(posedge clk_i);
    $display("run time limit reached before the stimulus finished");
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: list.f
irq_ctrl_pkg.sv
irq_pend_if.sv
irq_pending_regs.sv
irq_arbiter.sv
wfi_sleep_ctrl.sv
irq_out_stage.sv
irq_ctrl_top.sv
irq_ctrl_sva.sv
tb_irq_ctrl.sv
